// ==== rtl/hyper_pkg.sv ====
`default_nettype none

package hyper_pkg;

  localparam int N_LANES    = 4;
  localparam int LANE_DEPTH = 16;
  localparam int LANE_AW    = $clog2(LANE_DEPTH);

  typedef logic [31:0]                word_t;
  typedef logic [$clog2(N_LANES)-1:0] lane_t;
  typedef logic [LANE_AW-1:0]         lane_ptr_t;
  typedef logic [LANE_AW:0]           lane_cnt_t;  // Counts up to LANE_DEPTH

  localparam lane_cnt_t LANE_FULL = lane_cnt_t'(LANE_DEPTH);

  // Push side of a lane
  typedef struct packed {
    logic  valid;
    word_t data;
  } lane_wr_t;

  // Pop side with the head word
  typedef struct packed {
    logic  valid;
    word_t data;
  } lane_rd_t;

endpackage

`default_nettype wire

// ==== rtl/blck_pkg.sv ====
`default_nettype none

package blck_pkg;

  import hyper_pkg::*;

  localparam int MEM_AW = 8;
  localparam int CNT_W  = 6;

  typedef logic [MEM_AW-1:0] addr_t;
  typedef logic [CNT_W-1:0]  count_t;

  typedef enum logic {
    OP_FILL,
    OP_EMPTY
  } blck_op_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_DONE
  } mvblck_state_e;

  typedef struct packed {
    blck_op_e op;
    lane_t    lane;
    addr_t    start;
    count_t   count;
  } blck_cmd_t;

  typedef struct packed {
    blck_op_e op;
    lane_t    lane;
    count_t   count_sent;
  } blck_done_t;

  // All zeros when the requester is idle
  typedef struct packed {
    logic  en;
    logic  we;
    addr_t addr;
    word_t data;
  } mem_req_t;

endpackage

`default_nettype wire

// ==== rtl/lsab_in.sv ====
`default_nettype none

module lsab_in
  import hyper_pkg::*;
(
  input  wire logic          CLK_n,
  input  wire logic          RST,
  input  wire lane_wr_t      i_lane_wr [N_LANES],
  output logic [N_LANES-1:0] o_lane_ready,
  input  wire lane_t         i_pop_lane,
  input  wire logic          i_pop,
  output lane_rd_t           o_pop_data
);

  word_t              mem [N_LANES][LANE_DEPTH];
  lane_ptr_t          wr_ptr [N_LANES];
  lane_ptr_t          rd_ptr [N_LANES];
  lane_cnt_t          cnt [N_LANES];
  logic [N_LANES-1:0] push;
  logic [N_LANES-1:0] pop;

  always_comb
  begin
    for (int k = 0; k < N_LANES; k++)
    begin
      o_lane_ready[k] = (cnt[k] != LANE_FULL);
      push[k]         = i_lane_wr[k].valid && o_lane_ready[k];
      pop[k]          = i_pop && (i_pop_lane == lane_t'(k));
    end
  end

  // Head of the lane picked by the fill mover
  assign o_pop_data = '{valid: (cnt[i_pop_lane] != '0),
                        data:  mem[i_pop_lane][rd_ptr[i_pop_lane]]};

  always_ff @(posedge CLK_n)
  begin
    for (int k = 0; k < N_LANES; k++)
    begin
      if (push[k])
        mem[k][wr_ptr[k]] <= i_lane_wr[k].data;
    end
  end

  // --------------------------------------------------
  always_ff @(posedge CLK_n)
  begin
    if (!RST)
    begin
      for (int k = 0; k < N_LANES; k++)
      begin
        wr_ptr[k] <= '0;
        rd_ptr[k] <= '0;
        cnt[k]    <= '0;
      end
    end
    else
    begin
      for (int k = 0; k < N_LANES; k++)
      begin
        if (push[k])
          wr_ptr[k] <= wr_ptr[k] + 1'b1;
        if (pop[k])
          rd_ptr[k] <= rd_ptr[k] + 1'b1;
        case ({push[k], pop[k]})
          2'b10:   cnt[k] <= cnt[k] + 1'b1;
          2'b01:   cnt[k] <= cnt[k] - 1'b1;
          default: cnt[k] <= cnt[k];     // Both or neither
        endcase
      end
    end
  end

  // Fill mover only pops a lane that holds data
  a_pop_nonempty: assert property (@(posedge CLK_n) disable iff (!RST)
    i_pop |-> o_pop_data.valid);

endmodule

`default_nettype wire

// ==== rtl/lsab_out.sv ====
`default_nettype none

module lsab_out
  import hyper_pkg::*;
(
  input  wire logic               CLK_n,
  input  wire logic               RST,
  input  wire lane_t              i_push_lane,
  input  wire lane_wr_t           i_push,
  output logic                    o_full_sel,
  output lane_rd_t                o_lane_rd [N_LANES],
  input  wire logic [N_LANES-1:0] i_lane_ready
);

  word_t              mem [N_LANES][LANE_DEPTH];
  lane_ptr_t          wr_ptr [N_LANES];
  lane_ptr_t          rd_ptr [N_LANES];
  lane_cnt_t          cnt [N_LANES];
  logic [N_LANES-1:0] push;
  logic [N_LANES-1:0] pop;

  always_comb
  begin
    for (int k = 0; k < N_LANES; k++)
    begin
      o_lane_rd[k] = '{valid: (cnt[k] != '0), data: mem[k][rd_ptr[k]]};
      push[k]      = i_push.valid && (i_push_lane == lane_t'(k));
      pop[k]       = o_lane_rd[k].valid && i_lane_ready[k];
    end
  end

  assign o_full_sel = (cnt[i_push_lane] == LANE_FULL);

  always_ff @(posedge CLK_n)
  begin
    for (int k = 0; k < N_LANES; k++)
    begin
      if (push[k])
        mem[k][wr_ptr[k]] <= i_push.data;
    end
  end

  // --------------------------------------------------
  always_ff @(posedge CLK_n)
  begin
    if (!RST)
    begin
      for (int k = 0; k < N_LANES; k++)
      begin
        wr_ptr[k] <= '0;
        rd_ptr[k] <= '0;
        cnt[k]    <= '0;
      end
    end
    else
    begin
      for (int k = 0; k < N_LANES; k++)
      begin
        if (push[k])
          wr_ptr[k] <= wr_ptr[k] + 1'b1;
        if (pop[k])
          rd_ptr[k] <= rd_ptr[k] + 1'b1;
        case ({push[k], pop[k]})
          2'b10:   cnt[k] <= cnt[k] + 1'b1;
          2'b01:   cnt[k] <= cnt[k] - 1'b1;
          default: cnt[k] <= cnt[k];
        endcase
      end
    end
  end

  // Empty mover holds back words while the lane is full
  a_push_notfull: assert property (@(posedge CLK_n) disable iff (!RST)
    i_push.valid |-> !o_full_sel);

endmodule

`default_nettype wire

// ==== rtl/mvblck_todram.sv ====
`default_nettype none

module mvblck_todram
  import hyper_pkg::*, blck_pkg::*;
(
  input  wire logic      CLK_n,
  input  wire logic      RST,
  input  wire blck_cmd_t i_cmd,
  input  wire logic      i_cmd_take,
  output logic           o_busy,
  output lane_t          o_pop_lane,
  output logic           o_pop,
  input  wire lane_rd_t  i_pop_data,
  output mem_req_t       o_mem,
  output blck_done_t     o_done,
  output logic           o_done_valid
);

  mvblck_state_e state;
  lane_t         lane_q;
  addr_t         addr_q;
  count_t        left_q;   // Words still to move
  count_t        sent_q;
  logic          take;

  assign take   = i_cmd_take && (i_cmd.op == OP_FILL);
  assign o_busy = (state != ST_IDLE);

  // Stalls while the lane is empty
  assign o_pop_lane = lane_q;
  assign o_pop      = (state == ST_RUN) && i_pop_data.valid;

  // Popped word goes straight to memory
  assign o_mem = '{en:   o_pop,
                   we:   o_pop,
                   addr: o_pop ? addr_q : '0,
                   data: o_pop ? i_pop_data.data : '0};

  assign o_done_valid = (state == ST_DONE);
  assign o_done       = o_done_valid ? {OP_FILL, lane_q, sent_q} : '0;

  always_ff @(posedge CLK_n)
  begin
    if (!RST)
    begin
      state  <= ST_IDLE;
      lane_q <= '0;
      addr_q <= '0;
      left_q <= '0;
      sent_q <= '0;
    end
    else
    begin
      case (state)
        ST_IDLE:
          if (take)
          begin
            lane_q <= i_cmd.lane;
            addr_q <= i_cmd.start;
            left_q <= i_cmd.count;
            sent_q <= '0;
            state  <= (i_cmd.count == '0) ? ST_DONE : ST_RUN;
          end
        ST_RUN:
          if (o_pop)
          begin
            addr_q <= addr_q + 1'b1;   // Wraps at 256
            left_q <= left_q - 1'b1;
            sent_q <= sent_q + 1'b1;
            if (left_q == count_t'(1))
              state <= ST_DONE;
          end
        default:
          state <= ST_IDLE;            // ST_DONE lasts one cycle
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/mvblck_frdram.sv ====
`default_nettype none

module mvblck_frdram
  import hyper_pkg::*, blck_pkg::*;
(
  input  wire logic      CLK_n,
  input  wire logic      RST,
  input  wire blck_cmd_t i_cmd,
  input  wire logic      i_cmd_take,
  output logic           o_busy,
  output mem_req_t       o_mem,
  input  wire word_t     i_mem_rdata,
  output lane_t          o_push_lane,
  output lane_wr_t       o_push,
  input  wire logic      i_full_sel,
  output blck_done_t     o_done,
  output logic           o_done_valid
);

  mvblck_state_e state;
  lane_t         lane_q;
  addr_t         addr_q;
  count_t        left_q;      // Reads still to issue
  count_t        sent_q;
  logic          rd_pend;     // Read data arrives this cycle
  logic          hold_valid;
  word_t         hold_q;
  logic          take;
  logic          issue;
  logic          word_rdy;
  logic          last;
  logic [1:0]    fly;

  assign take   = i_cmd_take && (i_cmd.op == OP_EMPTY);
  assign o_busy = (state != ST_IDLE);

  // No new read once the lane reports full
  assign issue = (state == ST_RUN) && (left_q != '0) && !i_full_sel;

  assign o_mem = '{en:   issue,
                   we:   1'b0,
                   addr: issue ? addr_q : '0,
                   data: '0};

  // --------------------------------------------------
  // Parked word is older than any returning one
  assign word_rdy    = hold_valid || rd_pend;
  assign o_push_lane = lane_q;
  assign o_push      = '{valid: word_rdy && !i_full_sel,
                         data:  hold_valid ? hold_q : i_mem_rdata};

  // Last word leaves this cycle or nothing is left
  assign last = (left_q == '0) && !(word_rdy && i_full_sel);

  assign o_done_valid = (state == ST_DONE);
  assign o_done       = o_done_valid ? {OP_EMPTY, lane_q, sent_q} : '0;

  always_ff @(posedge CLK_n)
  begin
    if (rd_pend && i_full_sel)
      hold_q <= i_mem_rdata;
  end

  always_ff @(posedge CLK_n)
  begin
    if (!RST)
    begin
      state      <= ST_IDLE;
      lane_q     <= '0;
      addr_q     <= '0;
      left_q     <= '0;
      sent_q     <= '0;
      rd_pend    <= 1'b0;
      hold_valid <= 1'b0;
    end
    else
    begin
      rd_pend <= issue;
      if (rd_pend && i_full_sel)
        hold_valid <= 1'b1;
      else if (o_push.valid)
        hold_valid <= 1'b0;
      if (o_push.valid)
        sent_q <= sent_q + 1'b1;
      case (state)
        ST_IDLE:
          if (take)
          begin
            lane_q <= i_cmd.lane;
            addr_q <= i_cmd.start;
            left_q <= i_cmd.count;
            sent_q <= '0;
            state  <= (i_cmd.count == '0) ? ST_DONE : ST_RUN;
          end
        ST_RUN:
        begin
          if (issue)
          begin
            addr_q <= addr_q + 1'b1;
            left_q <= left_q - 1'b1;
          end
          if (last)
            state <= ST_DONE;
        end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // Holding slot plus memory pipe never exceed two words
  assign fly = {1'b0, hold_valid} + {1'b0, rd_pend} + {1'b0, issue};

  a_fly_max: assert property (@(posedge CLK_n) disable iff (!RST)
    fly <= 2'd2);

endmodule

`default_nettype wire

// ==== rtl/blck_mem.sv ====
`default_nettype none

module blck_mem
  import hyper_pkg::*, blck_pkg::*;
(
  input  wire logic     CLK_n,
  input  wire mem_req_t i_req_fill,
  input  wire mem_req_t i_req_empty,
  output word_t         o_rdata
);

  word_t    mem [2**MEM_AW];
  mem_req_t req;

  // Idle mover drives zeros
  assign req = i_req_fill | i_req_empty;

  always_ff @(posedge CLK_n)
  begin
    if (req.en && req.we)
      mem[req.addr] <= req.data;
  end

  always_ff @(posedge CLK_n)
  begin
    if (req.en && !req.we)
      o_rdata <= mem[req.addr];   // Valid the cycle after the read
  end

  // Only one mover is active at a time
  a_one_requester: assert property (@(posedge CLK_n)
    !((i_req_fill.en === 1'b1) && (i_req_empty.en === 1'b1)));

endmodule

`default_nettype wire

// ==== rtl/hyper_fabric.sv ====
`default_nettype none

module hyper_fabric
  import hyper_pkg::*, blck_pkg::*;
(
  input  wire logic               CLK_n,
  input  wire logic               RST,
  input  wire lane_wr_t           i_lane_wr [N_LANES],
  output logic [N_LANES-1:0]      o_lane_ready,
  output lane_rd_t                o_lane_rd [N_LANES],
  input  wire logic [N_LANES-1:0] i_lane_ready,
  input  wire blck_cmd_t          i_cmd,
  input  wire logic               i_cmd_valid,
  output logic                    o_cmd_ready,
  output blck_done_t              o_done,
  output logic                    o_done_valid
);

  logic       cmd_take;
  logic       busy_fill;
  logic       busy_empty;
  lane_t      pop_lane;
  logic       pop;
  lane_rd_t   pop_data;
  lane_t      push_lane;
  lane_wr_t   push;
  logic       full_sel;
  mem_req_t   mem_fill;
  mem_req_t   mem_empty;
  word_t      mem_rdata;
  blck_done_t done_fill;
  blck_done_t done_empty;
  logic       dv_fill;
  logic       dv_empty;

  // One transfer in progress at a time
  assign o_cmd_ready  = !(busy_fill || busy_empty);
  assign cmd_take     = i_cmd_valid && o_cmd_ready;
  assign o_done       = done_fill | done_empty;
  assign o_done_valid = dv_fill || dv_empty;

  // --------------------------------------------------
  lsab_in u_lsab_in (
    .CLK_n        (CLK_n),
    .RST          (RST),
    .i_lane_wr    (i_lane_wr),
    .o_lane_ready (o_lane_ready),
    .i_pop_lane   (pop_lane),
    .i_pop        (pop),
    .o_pop_data   (pop_data)
  );

  mvblck_todram u_fill (
    .CLK_n        (CLK_n),
    .RST          (RST),
    .i_cmd        (i_cmd),
    .i_cmd_take   (cmd_take),
    .o_busy       (busy_fill),
    .o_pop_lane   (pop_lane),
    .o_pop        (pop),
    .i_pop_data   (pop_data),
    .o_mem        (mem_fill),
    .o_done       (done_fill),
    .o_done_valid (dv_fill)
  );

  blck_mem u_mem (
    .CLK_n       (CLK_n),
    .i_req_fill  (mem_fill),
    .i_req_empty (mem_empty),
    .o_rdata     (mem_rdata)
  );

  mvblck_frdram u_empty (
    .CLK_n        (CLK_n),
    .RST          (RST),
    .i_cmd        (i_cmd),
    .i_cmd_take   (cmd_take),
    .o_busy       (busy_empty),
    .o_mem        (mem_empty),
    .i_mem_rdata  (mem_rdata),
    .o_push_lane  (push_lane),
    .o_push       (push),
    .i_full_sel   (full_sel),
    .o_done       (done_empty),
    .o_done_valid (dv_empty)
  );

  lsab_out u_lsab_out (
    .CLK_n        (CLK_n),
    .RST          (RST),
    .i_push_lane  (push_lane),
    .i_push       (push),
    .o_full_sel   (full_sel),
    .o_lane_rd    (o_lane_rd),
    .i_lane_ready (i_lane_ready)
  );

endmodule

`default_nettype wire

// ==== verif/tb_hyper_tasks.svh ====
`ifndef TB_HYPER_TASKS_SVH
`define TB_HYPER_TASKS_SVH

word_t model_mem [2**MEM_AW];   // Expected memory image

// --------------------------------------------------
// Compare tasks

task automatic check_done(input blck_done_t got, input blck_done_t exp);
  if (got !== exp)
  begin
    $display("Fail o_done: got 0x%h expected 0x%h", got, exp);
    fail_stop();
  end
endtask

task automatic check_word(input string name, input word_t got, input word_t exp);
  if (got !== exp)
  begin
    $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
    fail_stop();
  end
endtask

task automatic check_ready(input string name, input logic got, input logic exp);
  if (got !== exp)
  begin
    $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
    fail_stop();
  end
endtask

// --------------------------------------------------
// Lane tasks

task automatic next_cycle();
  @(posedge CLK_n);
  #2;                            // Drive and sample point
endtask

// Pushes words into one input lane while honouring its ready
task automatic push_lane_words(input lane_t lane, input word_t words [$]);
  int idx;
  int waited;

  idx    = 0;
  waited = 0;
  while (idx < words.size())
  begin
    wr_lanes[lane] = '{valid: 1'b1, data: words[idx]};
    if (wr_ready[lane])
      idx++;
    next_cycle();
    waited++;
    if (waited == TIMEOUT)
    begin
      $display("Timeout while pushing words into input lane %0d", lane);
      fail_stop();
    end
  end
  wr_lanes[lane] = '0;
endtask

// Every output lane except one must be empty
task automatic check_idle_lanes(input int except);
  int k;

  for (k = 0; k < N_LANES; k++)
  begin
    if (k != except)
      check_ready($sformatf("o_lane_rd[%0d].valid", k), rd_lanes[k].valid, 1'b0);
  end
endtask

`endif

// ==== verif/tb_hyper_fabric.sv ====
`default_nettype none

module tb_hyper_fabric
  import hyper_pkg::*, blck_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 2000;   // Cycles per wait
  localparam int N_ROWS  = 10;

  typedef struct {
    blck_op_e op;
    lane_t    lane;
    addr_t    start;
    count_t   count;
    bit       pre;        // Fill data pushed before the command
    int       drain;      // Cycles before the output lane is drained
    count_t   exp_sent;
  } row_t;

  logic               CLK_n;
  logic               RST;
  lane_wr_t           wr_lanes [N_LANES];
  logic [N_LANES-1:0] wr_ready;
  lane_rd_t           rd_lanes [N_LANES];
  logic [N_LANES-1:0] rd_ready;
  blck_cmd_t          cmd;
  logic               cmd_valid;
  logic               cmd_ready;
  blck_done_t         done;
  logic               done_valid;
  row_t               rows [N_ROWS];

  initial
  begin
    CLK_n = 1'b0;
  end

  always #20 CLK_n = ~CLK_n;

  hyper_fabric i_dut (
    .CLK_n        (CLK_n),
    .RST          (RST),
    .i_lane_wr    (wr_lanes),
    .o_lane_ready (wr_ready),
    .o_lane_rd    (rd_lanes),
    .i_lane_ready (rd_ready),
    .i_cmd        (cmd),
    .i_cmd_valid  (cmd_valid),
    .o_cmd_ready  (cmd_ready),
    .o_done       (done),
    .o_done_valid (done_valid)
  );

  task automatic fail_stop();
    $display("** FAIL **");
    $fatal(1, "Stopped at first error");
  endtask

  `include "tb_hyper_tasks.svh"

  task automatic wait_cmd_ready();
    int waited;

    waited = 0;
    while (!cmd_ready)
    begin
      next_cycle();
      waited++;
      if (waited == TIMEOUT)
      begin
        $display("Timeout waiting for the command port to become ready");
        fail_stop();
      end
    end
  endtask

  // --------------------------------------------------
  // Applies one table row and watches the DUT each cycle
  task automatic run_row(input row_t r);
    word_t      words [$];
    blck_done_t exp;
    int         i;
    int         pushed;
    int         got;
    int         cyc;
    bit         seen;

    exp    = '{op: r.op, lane: r.lane, count_sent: r.exp_sent};
    pushed = 0;
    got    = 0;
    cyc    = 0;
    seen   = 1'b0;
    if (r.op == OP_FILL)
    begin
      for (i = 0; i < r.count; i++)
        words.push_back($urandom);
      if (r.pre)
      begin
        push_lane_words(r.lane, words);
        pushed = r.count;
      end
    end

    wait_cmd_ready();
    cmd       = '{op: r.op, lane: r.lane, start: r.start, count: r.count};
    cmd_valid = 1'b1;
    next_cycle();
    cmd_valid = 1'b0;
    cmd       = '0;

    while (!seen || (r.op == OP_EMPTY && got < int'(r.count)))
    begin
      if (seen)
        check_ready("o_done_valid", done_valid, 1'b0);   // Single pulse
      else if (done_valid)
      begin
        check_done(done, exp);
        seen = 1'b1;
      end
      else
        check_ready("o_cmd_ready", cmd_ready, 1'b0);

      if (r.op == OP_FILL)
      begin
        check_idle_lanes(-1);
        if (pushed < int'(r.count) && (cyc % 3 != 2))   // Gaps in the lane data
        begin
          wr_lanes[r.lane] = '{valid: 1'b1, data: words[pushed]};
          if (wr_ready[r.lane])
            pushed++;
        end
        else
          wr_lanes[r.lane] = '0;
      end
      else
      begin
        check_idle_lanes(r.lane);
        if (cyc == r.drain && r.count > LANE_DEPTH && seen)
        begin
          $display("Empty transfer finished while its output lane was blocked");
          fail_stop();
        end
        if (cyc >= r.drain)
        begin
          rd_ready[r.lane] = 1'b1;
          if (rd_lanes[r.lane].valid)
          begin
            check_word($sformatf("o_lane_rd[%0d].data", r.lane), rd_lanes[r.lane].data,
                       model_mem[addr_t'(r.start + got)]);
            got++;
          end
        end
      end

      next_cycle();
      cyc++;
      if (cyc == TIMEOUT)
      begin
        $display("Timeout in %s transfer on lane %0d", r.op.name(), r.lane);
        fail_stop();
      end
    end

    wr_lanes[r.lane] = '0;
    rd_ready         = '0;
    if (r.op == OP_FILL)
    begin
      if (pushed != int'(r.count))
      begin
        $display("Fill reported done before all lane words were pushed");
        fail_stop();
      end
      for (i = 0; i < r.count; i++)
        model_mem[addr_t'(r.start + i)] = words[i];
    end
    check_ready("o_cmd_ready", cmd_ready, 1'b1);
    check_ready("o_done_valid", done_valid, 1'b0);
    check_idle_lanes(-1);
  endtask

  // --------------------------------------------------
  initial
  begin
    void'($urandom(93));
    RST       = 1'b0;
    rd_ready  = '0;
    cmd       = '0;
    cmd_valid = 1'b0;
    for (int k = 0; k < N_LANES; k++)
      wr_lanes[k] = '0;

    rows[0] = '{OP_FILL,  2'd0, 8'h10, 6'd8,  1'b1, 0,  6'd8};
    rows[1] = '{OP_EMPTY, 2'd0, 8'h10, 6'd8,  1'b0, 0,  6'd8};
    rows[2] = '{OP_FILL,  2'd3, 8'hFC, 6'd6,  1'b1, 0,  6'd6};   // Wraps past 0xFF
    rows[3] = '{OP_EMPTY, 2'd1, 8'hFC, 6'd6,  1'b0, 0,  6'd6};
    rows[4] = '{OP_FILL,  2'd2, 8'h40, 6'd10, 1'b0, 0,  6'd10};
    rows[5] = '{OP_EMPTY, 2'd2, 8'h40, 6'd10, 1'b0, 3,  6'd10};
    rows[6] = '{OP_FILL,  2'd1, 8'h80, 6'd20, 1'b0, 0,  6'd20};
    rows[7] = '{OP_EMPTY, 2'd2, 8'h80, 6'd20, 1'b0, 30, 6'd20};  // Lane fills up
    rows[8] = '{OP_FILL,  2'd0, 8'h20, 6'd0,  1'b1, 0,  6'd0};
    rows[9] = '{OP_EMPTY, 2'd3, 8'h20, 6'd0,  1'b0, 0,  6'd0};

    next_cycle();
    next_cycle();
    RST = 1'b1;
    next_cycle();

    check_ready("o_cmd_ready", cmd_ready, 1'b1);
    check_ready("o_done_valid", done_valid, 1'b0);
    for (int k = 0; k < N_LANES; k++)
      check_ready($sformatf("o_lane_ready[%0d]", k), wr_ready[k], 1'b1);
    check_idle_lanes(-1);

    for (int n = 0; n < N_ROWS; n++)
      run_row(rows[n]);

    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hyper_fabric.f ====
+incdir+verif
rtl/hyper_pkg.sv
rtl/blck_pkg.sv
rtl/lsab_in.sv
rtl/lsab_out.sv
rtl/mvblck_todram.sv
rtl/mvblck_frdram.sv
rtl/blck_mem.sv
rtl/hyper_fabric.sv
verif/tb_hyper_fabric.sv
